//--- coproc_pkg.sv
/*
  Shared definitions for the finite-field coprocessor
  Element widths, memory address types, instruction and stream formats
*/
package coproc_pkg;

  localparam int ELEM_BITS      = 16;
  localparam int READ_CYCLE     = 2;
  localparam int ADDSUB_LATENCY = 2;

  typedef logic [ELEM_BITS-1:0] elem_t;
  typedef logic [7:0]           slot_addr_t;
  typedef logic [5:0]           inst_addr_t;

  // Unlisted codes are skipped by the sequencer
  typedef enum logic [3:0] {
    OP_NOOP_WAIT = 4'h0,
    OP_COPY      = 4'h1,
    OP_ADD       = 4'h2,
    OP_SUB       = 4'h3,
    OP_SEND_IRQ  = 4'h4
  } opcode_e;

  // FE2 spans two consecutive slots
  typedef enum logic [3:0] {
    PT_FE  = 4'h1,
    PT_FE2 = 4'h2
  } point_type_e;

  typedef struct packed {
    opcode_e    code;
    slot_addr_t a;
    slot_addr_t b;
    slot_addr_t c;
  } inst_t;

  typedef struct packed {
    point_type_e pt;
    elem_t       dat;
  } slot_word_t;

  typedef struct packed {
    logic       we;
    inst_addr_t addr;
    inst_t      inst;
  } inst_wr_t;

  typedef struct packed {
    logic       we;
    slot_addr_t addr;
    slot_word_t word;
  } data_wr_t;

  typedef struct packed {
    logic  val;
    logic  sub;
    elem_t x;
    elem_t y;
  } addsub_req_t;

  typedef struct packed {
    logic  val;
    elem_t dat;
  } addsub_res_t;

  // Same layout as the packet header word
  typedef struct packed {
    slot_addr_t  b;
    point_type_e pt;
    logic [3:0]  cnt;
  } irq_idx_t;

  typedef struct packed {
    logic  sop;
    logic  eop;
    elem_t dat;
  } tx_word_t;

endpackage

//--- coproc_mem.sv
/*
  Instruction and slot memories
  Host write ports plus a registered address and output for a two-cycle read
*/
`timescale 1ns/1ps

module coproc_mem
  import coproc_pkg::*;
(
  input  logic       i_clk,
  input  logic       i_rst,
  input  inst_wr_t   i_inst_wr,
  input  data_wr_t   i_data_wr,
  input  inst_addr_t i_inst_addr,
  output inst_t      o_inst,
  input  slot_addr_t i_data_addr,
  input  logic       i_data_we,
  input  slot_word_t i_data_wdata,
  output slot_word_t o_data
);

  localparam int INST_DEPTH = 2**$bits(inst_addr_t);
  localparam int SLOT_DEPTH = 2**$bits(slot_addr_t);

  inst_t      inst_mem [INST_DEPTH];
  slot_word_t slot_mem [SLOT_DEPTH];

  inst_addr_t inst_addr_q;
  slot_addr_t data_addr_q;

  always_ff @(posedge i_clk) begin
    if (i_inst_wr.we) begin
      inst_mem[i_inst_wr.addr] <= i_inst_wr.inst;
    end
  end

  // Host only writes while halted, so it never races the sequencer
  always_ff @(posedge i_clk) begin
    if (i_data_wr.we) begin
      slot_mem[i_data_wr.addr] <= i_data_wr.word;
    end else if (i_data_we) begin
      slot_mem[i_data_addr] <= i_data_wdata;
    end
  end

  // First read cycle
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      inst_addr_q <= '0;
      data_addr_q <= '0;
    end else begin
      inst_addr_q <= i_inst_addr;
      data_addr_q <= i_data_addr;
    end
  end

  // Second read cycle
  always_ff @(posedge i_clk) begin
    o_inst <= inst_mem[inst_addr_q];
    o_data <= slot_mem[data_addr_q];
  end

endmodule

//--- coproc_sequencer.sv
/*
  Instruction sequencer
  Fetches and decodes from instruction memory, runs copy, add, subtract
  and send-interrupt instructions against slot memory
*/
`timescale 1ns/1ps

module coproc_sequencer
  import coproc_pkg::*;
(
  input  logic        i_clk,
  input  logic        i_rst,
  input  logic        i_start,
  input  inst_addr_t  i_start_pt,
  output logic        o_halted,
  output inst_addr_t  o_inst_addr,
  input  inst_t       i_inst,
  output slot_addr_t  o_data_addr,
  output logic        o_data_we,
  output slot_word_t  o_data_wdata,
  input  slot_word_t  i_data,
  output addsub_req_t o_req,
  input  addsub_res_t i_res,
  output logic        o_idx_push,
  output irq_idx_t    o_idx,
  input  logic        i_idx_full,
  output logic        o_word_push,
  output elem_t       o_word,
  input  logic        i_word_full
);

  typedef enum logic [2:0] {FETCH, NOOP_WAIT, COPY, ARITH, SEND} state_e;

  state_e              state;
  logic [READ_CYCLE:0] rd_pend;
  logic [2:0]          step;
  logic [1:0]          word_idx;
  logic                start_pend;
  inst_addr_t          start_pt_q;
  inst_t               inst_q;
  elem_t               x_q;
  point_type_e         pt_q;
  logic                rd_done;
  logic                is_fe2;

  assign rd_done  = rd_pend[READ_CYCLE];
  assign is_fe2   = (pt_q == PT_FE2);
  assign o_halted = (state == NOOP_WAIT) && !start_pend;

  task fetch_at(input inst_addr_t addr);
    o_inst_addr <= addr;
    rd_pend[0]  <= 1'b1;
    step        <= '0;
    state       <= FETCH;
  endtask

  task read_slot(input slot_addr_t addr);
    o_data_addr <= addr;
    rd_pend[0]  <= 1'b1;
  endtask

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state       <= NOOP_WAIT;
      o_inst_addr <= '0;
      rd_pend     <= '0;
      step        <= '0;
      word_idx    <= '0;
      start_pend  <= 1'b0;
      o_data_we   <= 1'b0;
      o_req.val   <= 1'b0;
      o_idx_push  <= 1'b0;
      o_word_push <= 1'b0;
    end else begin
      rd_pend     <= rd_pend << 1;
      o_data_we   <= 1'b0;
      o_req.val   <= 1'b0;
      o_idx_push  <= 1'b0;
      o_word_push <= 1'b0;

      case (state)
        NOOP_WAIT: begin
          if (start_pend) begin
            start_pend <= 1'b0;
            fetch_at(start_pt_q);
          end
        end
        FETCH: begin
          if (rd_done) begin
            inst_q   <= i_inst;
            word_idx <= '0;
            case (i_inst.code)
              OP_NOOP_WAIT:   state <= NOOP_WAIT;
              OP_COPY:        state <= COPY;
              OP_ADD, OP_SUB: state <= ARITH;
              OP_SEND_IRQ:    state <= SEND;
              default:        fetch_at(o_inst_addr + 1'b1);
            endcase
          end
        end
        COPY: begin
          if (step == 3'd0) begin
            read_slot(inst_q.a);
            step <= 3'd1;
          end else if (rd_done) begin
            o_data_addr  <= inst_q.b;
            o_data_wdata <= i_data;
            o_data_we    <= 1'b1;
            fetch_at(o_inst_addr + 1'b1);
          end
        end
        ARITH: begin
          // Reads a, b, a+1, b+1 back to back; upper pair ignored for FE
          if (step < 3'd4) begin
            step <= step + 1'b1;
            case (step[1:0])
              2'd0:    read_slot(inst_q.a);
              2'd1:    read_slot(inst_q.b);
              2'd2:    read_slot(inst_q.a + 1'b1);
              default: read_slot(inst_q.b + 1'b1);
            endcase
          end
          if (rd_done) begin
            word_idx <= word_idx + 1'b1;
            if (word_idx == 2'd0) pt_q <= i_data.pt;
            if (!word_idx[0]) begin
              x_q <= i_data.dat;
            end else if (word_idx == 2'd1 || is_fe2) begin
              o_req.val <= 1'b1;
              o_req.sub <= (inst_q.code == OP_SUB);
              o_req.x   <= x_q;
              o_req.y   <= i_data.dat;
            end
          end
          // Step 4 waits on the low result, step 5 on the high one
          if (i_res.val) begin
            o_data_addr      <= (step == 3'd4) ? inst_q.c : inst_q.c + 1'b1;
            o_data_wdata.pt  <= pt_q;
            o_data_wdata.dat <= i_res.dat;
            o_data_we        <= 1'b1;
            if (step == 3'd4 && is_fe2) begin
              step <= 3'd5;
            end else begin
              fetch_at(o_inst_addr + 1'b1);
            end
          end
        end
        SEND: begin
          case (step)
            3'd0: begin
              if (!i_idx_full && !i_word_full) begin
                read_slot(inst_q.a);
                step <= 3'd1;
              end
            end
            3'd1: begin
              if (rd_done) begin
                pt_q       <= i_data.pt;
                o_idx_push <= 1'b1;
                o_idx.b    <= inst_q.b;
                o_idx.pt   <= i_data.pt;
                o_idx.cnt  <= (i_data.pt == PT_FE2) ? 4'd2 : 4'd1;
                step       <= 3'd2;
              end
            end
            // Last push must land before the full flag is trusted again
            3'd2: begin
              if (!i_word_full && !o_word_push) begin
                read_slot(inst_q.a + word_idx);
                step <= 3'd3;
              end
            end
            default: begin
              if (rd_done) begin
                o_word_push <= 1'b1;
                o_word      <= i_data.dat;
                word_idx    <= word_idx + 1'b1;
                if (word_idx == 2'd1 || !is_fe2) begin
                  fetch_at(o_inst_addr + 1'b1);
                end else begin
                  step <= 3'd2;
                end
              end
            end
          endcase
        end
        default: state <= NOOP_WAIT;
      endcase

      if (i_start) begin
        start_pend <= 1'b1;
        start_pt_q <= i_start_pt;
      end
    end
  end

endmodule

//--- coproc_mod_addsub.sv
/*
  Two-stage modular adder and subtractor
  Raw sum or difference first, then a single correction by the modulus
*/
`timescale 1ns/1ps

module coproc_mod_addsub
  import coproc_pkg::*;
#(
  parameter int unsigned MODULUS = 65521
)(
  input  logic        i_clk,
  input  logic        i_rst,
  input  addsub_req_t i_req,
  output addsub_res_t o_res
);

  localparam logic [ELEM_BITS:0] MOD_EXT = (ELEM_BITS+1)'(MODULUS);

  logic [ADDSUB_LATENCY-1:0] val_pipe;
  logic [ELEM_BITS:0]        raw_q;
  logic                      sub_q;
  elem_t                     res_q;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      val_pipe <= '0;
    end else begin
      val_pipe <= {val_pipe[ADDSUB_LATENCY-2:0], i_req.val};
    end
  end

  // Extra top bit holds the carry or the borrow
  always_ff @(posedge i_clk) begin
    sub_q <= i_req.sub;
    if (i_req.sub) begin
      raw_q <= {1'b0, i_req.x} - {1'b0, i_req.y};
    end else begin
      raw_q <= {1'b0, i_req.x} + {1'b0, i_req.y};
    end
  end

  always_ff @(posedge i_clk) begin
    if (sub_q) begin
      res_q <= raw_q[ELEM_BITS] ? elem_t'(raw_q + MOD_EXT) : raw_q[ELEM_BITS-1:0];
    end else begin
      res_q <= (raw_q >= MOD_EXT) ? elem_t'(raw_q - MOD_EXT) : raw_q[ELEM_BITS-1:0];
    end
  end

  assign o_res.val = val_pipe[ADDSUB_LATENCY-1];
  assign o_res.dat = res_q;

endmodule

//--- coproc_fifo.sv
/*
  Small synchronous FIFO
  Circular buffer with full flag and a valid/ready output side
*/
`timescale 1ns/1ps

module coproc_fifo #(
  parameter int DEPTH      = 4,
  parameter int ENTRY_BITS = 16
)(
  input  logic                  i_clk,
  input  logic                  i_rst,
  input  logic                  i_push,
  input  logic [ENTRY_BITS-1:0] i_dat,
  output logic                  o_full,
  output logic                  o_val,
  output logic [ENTRY_BITS-1:0] o_dat,
  input  logic                  i_rdy
);

  localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_BITS = $clog2(DEPTH + 1);

  logic [ENTRY_BITS-1:0] mem [DEPTH];
  logic [PTR_BITS-1:0]   wr_ptr, rd_ptr;
  logic [CNT_BITS-1:0]   count;
  logic                  do_push, do_pop;

  assign o_full  = (count == CNT_BITS'(DEPTH));
  assign o_val   = (count != '0);
  assign o_dat   = mem[rd_ptr];
  // Push into a full FIFO is dropped
  assign do_push = i_push && !o_full;
  assign do_pop  = o_val && i_rdy;

  always_ff @(posedge i_clk) begin
    if (do_push) mem[wr_ptr] <= i_dat;
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) wr_ptr <= (wr_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (do_pop) rd_ptr <= (rd_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      count <= count + CNT_BITS'(do_push) - CNT_BITS'(do_pop);
    end
  end

endmodule

//--- coproc_irq_sender.sv
/*
  Interrupt packet sender
  Pops an index entry, sends the header word, then forwards the slot words
  with eop on the last one
*/
`timescale 1ns/1ps

module coproc_irq_sender
  import coproc_pkg::*;
(
  input  logic     i_clk,
  input  logic     i_rst,
  input  logic     i_idx_val,
  input  irq_idx_t i_idx,
  output logic     o_idx_rdy,
  input  logic     i_word_val,
  input  elem_t    i_word,
  output logic     o_word_rdy,
  output tx_word_t o_tx,
  output logic     o_tx_val,
  input  logic     i_tx_rdy
);

  typedef enum logic [1:0] {WAIT_IDX, SEND_HDR, SEND_DATA} state_e;

  state_e     state;
  irq_idx_t   idx_q;
  logic [3:0] words_left;
  logic       tx_free;

  // Output register can take a new word
  assign tx_free    = !o_tx_val || i_tx_rdy;
  assign o_idx_rdy  = (state == WAIT_IDX);
  assign o_word_rdy = (state == SEND_DATA) && tx_free;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state      <= WAIT_IDX;
      words_left <= '0;
      o_tx_val   <= 1'b0;
      o_tx.sop   <= 1'b0;
      o_tx.eop   <= 1'b0;
    end else begin
      if (o_tx_val && i_tx_rdy) begin
        o_tx_val <= 1'b0;
        o_tx.sop <= 1'b0;
        o_tx.eop <= 1'b0;
      end

      case (state)
        WAIT_IDX: begin
          if (i_idx_val) begin
            idx_q <= i_idx;
            state <= SEND_HDR;
          end
        end
        SEND_HDR: begin
          if (tx_free) begin
            o_tx.sop   <= 1'b1;
            o_tx.eop   <= 1'b0;
            o_tx.dat   <= idx_q;
            o_tx_val   <= 1'b1;
            words_left <= idx_q.cnt;
            state      <= SEND_DATA;
          end
        end
        default: begin
          if (tx_free && i_word_val) begin
            o_tx.eop   <= (words_left == 4'd1);
            o_tx.dat   <= i_word;
            o_tx_val   <= 1'b1;
            words_left <= words_left - 1'b1;
            if (words_left == 4'd1) state <= WAIT_IDX;
          end
        end
      endcase
    end
  end

endmodule

//--- coproc_top.sv
/*
  Finite-field coprocessor top level
  Host-loaded memories, sequencer with modular add/sub, packet output stream
*/
`timescale 1ns/1ps

module coproc_top
  import coproc_pkg::*;
#(
  parameter int unsigned MODULUS         = 65521,
  parameter int          IDX_FIFO_DEPTH  = 4,
  parameter int          WORD_FIFO_DEPTH = 4
)(
  input  logic       i_clk,
  input  logic       i_rst,
  input  inst_wr_t   i_inst_wr,
  input  data_wr_t   i_data_wr,
  input  logic       i_start,
  input  inst_addr_t i_start_pt,
  output logic       o_halted,
  output tx_word_t   o_tx,
  output logic       o_tx_val,
  input  logic       i_tx_rdy
);

  inst_addr_t  inst_addr;
  inst_t       inst;
  slot_addr_t  data_addr;
  logic        data_we;
  slot_word_t  data_wdata, data_rdata;
  addsub_req_t addsub_req;
  addsub_res_t addsub_res;
  logic        idx_push, idx_full, idx_val, idx_rdy;
  irq_idx_t    idx_in, idx_out;
  logic        word_push, word_full, word_val, word_rdy;
  elem_t       word_in, word_out;

  // Input side
  coproc_mem mem_inst (
    .i_clk (i_clk), .i_rst (i_rst),
    .i_inst_wr (i_inst_wr), .i_data_wr (i_data_wr),
    .i_inst_addr (inst_addr), .o_inst (inst),
    .i_data_addr (data_addr), .i_data_we (data_we),
    .i_data_wdata (data_wdata), .o_data (data_rdata)
  );

  // Processing
  coproc_sequencer seq_inst (
    .i_clk (i_clk), .i_rst (i_rst),
    .i_start (i_start), .i_start_pt (i_start_pt), .o_halted (o_halted),
    .o_inst_addr (inst_addr), .i_inst (inst),
    .o_data_addr (data_addr), .o_data_we (data_we),
    .o_data_wdata (data_wdata), .i_data (data_rdata),
    .o_req (addsub_req), .i_res (addsub_res),
    .o_idx_push (idx_push), .o_idx (idx_in), .i_idx_full (idx_full),
    .o_word_push (word_push), .o_word (word_in), .i_word_full (word_full)
  );

  coproc_mod_addsub #(.MODULUS(MODULUS)) addsub_inst (
    .i_clk (i_clk), .i_rst (i_rst), .i_req (addsub_req), .o_res (addsub_res)
  );

  // Output side
  coproc_fifo #(.DEPTH(IDX_FIFO_DEPTH), .ENTRY_BITS($bits(irq_idx_t))) idx_fifo (
    .i_clk (i_clk), .i_rst (i_rst), .i_push (idx_push), .i_dat (idx_in),
    .o_full (idx_full), .o_val (idx_val), .o_dat (idx_out), .i_rdy (idx_rdy)
  );

  coproc_fifo #(.DEPTH(WORD_FIFO_DEPTH), .ENTRY_BITS($bits(elem_t))) word_fifo (
    .i_clk (i_clk), .i_rst (i_rst), .i_push (word_push), .i_dat (word_in),
    .o_full (word_full), .o_val (word_val), .o_dat (word_out), .i_rdy (word_rdy)
  );

  coproc_irq_sender sender_inst (
    .i_clk (i_clk), .i_rst (i_rst),
    .i_idx_val (idx_val), .i_idx (idx_out), .o_idx_rdy (idx_rdy),
    .i_word_val (word_val), .i_word (word_out), .o_word_rdy (word_rdy),
    .o_tx (o_tx), .o_tx_val (o_tx_val), .i_tx_rdy (i_tx_rdy)
  );

endmodule

//--- coproc_asserts.sv
/*
  Bound checks on the transmit stream and the FIFO push sides
*/
`timescale 1ns/1ps

module coproc_asserts
  import coproc_pkg::*;
(
  input logic     i_clk,
  input logic     i_rst,
  input tx_word_t i_tx,
  input logic     i_tx_val,
  input logic     i_tx_rdy,
  input logic     i_idx_push,
  input logic     i_idx_full,
  input logic     i_word_push,
  input logic     i_word_full
);

  int fail_count = 0;

  // Word and valid hold while the receiver stalls
  tx_hold: assert property (@(posedge i_clk) disable iff (i_rst)
    i_tx_val && !i_tx_rdy |=> i_tx_val && $stable(i_tx))
  else begin
    fail_count++;
    $error("transmit word changed while stalled");
  end

  sop_valid: assert property (@(posedge i_clk) disable iff (i_rst) i_tx.sop |-> i_tx_val)
  else begin
    fail_count++;
    $error("sop set without valid");
  end

  idx_push_room: assert property (@(posedge i_clk) disable iff (i_rst)
    !(i_idx_push && i_idx_full))
  else begin
    fail_count++;
    $error("push into full index FIFO");
  end

  word_push_room: assert property (@(posedge i_clk) disable iff (i_rst)
    !(i_word_push && i_word_full))
  else begin
    fail_count++;
    $error("push into full word FIFO");
  end

endmodule

bind coproc_top coproc_asserts asserts_inst (
  .i_clk (i_clk), .i_rst (i_rst),
  .i_tx (o_tx), .i_tx_val (o_tx_val), .i_tx_rdy (i_tx_rdy),
  .i_idx_push (idx_push), .i_idx_full (idx_full),
  .i_word_push (word_push), .i_word_full (word_full)
);

//--- coproc_tb.sv
/*
  Directed testbench for the finite-field coprocessor
  Loads programs and slots, runs them and checks every transmit word against a model
*/
`timescale 1ns/1ps

module coproc_tb
  import coproc_pkg::*;
();

  localparam int unsigned MODULUS = 65521;
  localparam logic [31:0] SEED    = 32'h08bd_96fc;
  // Tests need about 4000 cycles, five times that as the limit
  localparam int TIMEOUT_CYCLES   = 20000;

  logic       i_clk = 1'b0;
  logic       i_rst;
  inst_wr_t   i_inst_wr;
  data_wr_t   i_data_wr;
  logic       i_start;
  inst_addr_t i_start_pt;
  logic       o_halted;
  tx_word_t   o_tx;
  logic       o_tx_val;
  logic       i_tx_rdy = 1'b1;

  slot_word_t  model [256];
  tx_word_t    exp_q [$];
  logic [31:0] op_rng;
  logic [31:0] rdy_rng = SEED;
  logic        rdy_random;
  inst_addr_t  pc;
  int          cycles = 0;
  int          stall_until = 0;

  coproc_top #(.MODULUS(MODULUS)) coproc_top_inst (
    .i_clk (i_clk), .i_rst (i_rst),
    .i_inst_wr (i_inst_wr), .i_data_wr (i_data_wr),
    .i_start (i_start), .i_start_pt (i_start_pt), .o_halted (o_halted),
    .o_tx (o_tx), .o_tx_val (o_tx_val), .i_tx_rdy (i_tx_rdy)
  );

  always #4 i_clk = ~i_clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Field arithmetic over the prime, done in plain integers
  function automatic elem_t field_op(input logic sub, input elem_t x, input elem_t y);
    int r;
    if (sub) begin
      r = (int'(x) - int'(y) + int'(MODULUS)) % int'(MODULUS);
    end else begin
      r = (int'(x) + int'(y)) % int'(MODULUS);
    end
    return elem_t'(r);
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("SOME TESTS FAILED");
    $fatal(1, "Simulation stopped on first error");
  endtask

  task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      abort_run($sformatf("Fail at %0t ns: %s is %h, expected %h", $time, what, got, exp));
    end
  endtask

  always @(posedge i_clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      abort_run($sformatf("Timeout: the run did not finish within %0d cycles", cycles));
    end
  end

  // Ready is high about three cycles in four when randomized
  // and held low during a stall window
  always @(posedge i_clk) begin
    if (cycles < stall_until) begin
      i_tx_rdy <= 1'b0;
    end else if (rdy_random) begin
      rdy_rng = xorshift32(rdy_rng);
      i_tx_rdy <= rdy_rng[0] | rdy_rng[1];
    end else begin
      i_tx_rdy <= 1'b1;
    end
  end

  task automatic collect_tx_word(input tx_word_t w);
    tx_word_t exp;
    if (exp_q.size() == 0) begin
      abort_run($sformatf("Transmit word %h arrived at %0t ns with no packet expected", w, $time));
    end else begin
      exp = exp_q.pop_front();
      check_eq(32'(w), 32'(exp), "tx word {sop,eop,data}");
    end
  endtask

  // Transfer happens at the next rising edge
  always @(negedge i_clk) begin
    if (!i_rst && o_tx_val && i_tx_rdy) begin
      collect_tx_word(o_tx);
    end
  end

  task automatic put_slot(input slot_addr_t addr, input point_type_e pt, input elem_t dat);
    data_wr_t w;
    w.we       = 1'b1;
    w.addr     = addr;
    w.word.pt  = pt;
    w.word.dat = dat;
    @(posedge i_clk);
    i_data_wr    <= w;
    i_inst_wr.we <= 1'b0;
    model[addr] = w.word;
  endtask

  // Writes one instruction and applies it to the model in program order
  task automatic put_inst(input opcode_e code, input slot_addr_t a, input slot_addr_t b,
                          input slot_addr_t c);
    inst_wr_t    w;
    tx_word_t    t;
    point_type_e pt;
    slot_addr_t  n;
    slot_addr_t  k;
    w.we        = 1'b1;
    w.addr      = pc;
    w.inst.code = code;
    w.inst.a    = a;
    w.inst.b    = b;
    w.inst.c    = c;
    @(posedge i_clk);
    i_inst_wr    <= w;
    i_data_wr.we <= 1'b0;
    pc = pc + 1'b1;
    pt = model[a].pt;
    n  = (pt == PT_FE2) ? 8'd2 : 8'd1;
    case (code)
      OP_COPY: model[b] = model[a];
      OP_ADD, OP_SUB: begin
        for (k = 8'd0; k < n; k++) begin
          model[c + k].pt  = pt;
          model[c + k].dat = field_op(code == OP_SUB, model[a + k].dat, model[b + k].dat);
        end
      end
      OP_SEND_IRQ: begin
        t.sop = 1'b1;
        t.eop = 1'b0;
        t.dat = {b, pt, n[3:0]};
        exp_q.push_back(t);
        for (k = 8'd0; k < n; k++) begin
          t.sop = 1'b0;
          t.eop = (k == n - 8'd1);
          t.dat = model[a + k].dat;
          exp_q.push_back(t);
        end
      end
      default: ;
    endcase
  endtask

  task automatic run_program(input inst_addr_t start_pt);
    @(posedge i_clk);
    i_inst_wr.we <= 1'b0;
    i_data_wr.we <= 1'b0;
    i_start      <= 1'b1;
    i_start_pt   <= start_pt;
    @(posedge i_clk);
    i_start <= 1'b0;
    @(negedge i_clk);
    check_eq(32'(o_halted), 32'd0, "o_halted after start");
    while (!o_halted) @(negedge i_clk);
    do @(posedge i_clk); while (exp_q.size() != 0);
  endtask

  task automatic check_idle_after_reset();
    int i;
    for (i = 0; i < 20; i++) begin
      @(negedge i_clk);
      check_eq(32'(o_halted), 32'd1, "o_halted after reset");
      check_eq(32'(o_tx_val), 32'd0, "o_tx_val after reset");
    end
  endtask

  // Sum at the modulus, sum past it, a below b and a equal to b
  task automatic test_fe_arith();
    put_slot(8'd0, PT_FE, 16'd65520);
    put_slot(8'd1, PT_FE, 16'd1);
    put_slot(8'd2, PT_FE, 16'd65000);
    put_slot(8'd3, PT_FE, 16'd1000);
    put_slot(8'd4, PT_FE, 16'd5);
    put_slot(8'd5, PT_FE, 16'd9);
    pc = '0;
    put_inst(OP_ADD, 8'd0, 8'd1, 8'd16);
    put_inst(OP_SEND_IRQ, 8'd16, 8'd16, 8'd0);
    put_inst(OP_ADD, 8'd2, 8'd3, 8'd17);
    put_inst(OP_SEND_IRQ, 8'd17, 8'd17, 8'd0);
    put_inst(OP_SUB, 8'd4, 8'd5, 8'd18);
    put_inst(OP_SEND_IRQ, 8'd18, 8'd18, 8'd0);
    put_inst(OP_SUB, 8'd3, 8'd3, 8'd19);
    put_inst(OP_SEND_IRQ, 8'd19, 8'd19, 8'd0);
    put_inst(OP_NOOP_WAIT, 8'd0, 8'd0, 8'd0);
    run_program(6'd0);
  endtask

  task automatic test_fe2_and_copy();
    put_slot(8'd32, PT_FE2, 16'd65500);
    put_slot(8'd33, PT_FE2, 16'd10);
    put_slot(8'd34, PT_FE2, 16'd30);
    put_slot(8'd35, PT_FE2, 16'd20);
    pc = '0;
    put_inst(OP_ADD, 8'd32, 8'd34, 8'd40);
    put_inst(OP_SEND_IRQ, 8'd40, 8'd40, 8'd0);
    put_inst(OP_SUB, 8'd32, 8'd34, 8'd42);
    put_inst(OP_SEND_IRQ, 8'd42, 8'd42, 8'd0);
    put_inst(OP_COPY, 8'd42, 8'd44, 8'd0);
    put_inst(OP_COPY, 8'd43, 8'd45, 8'd0);
    put_inst(OP_SEND_IRQ, 8'd44, 8'd44, 8'd0);
    put_inst(OP_NOOP_WAIT, 8'd0, 8'd0, 8'd0);
    run_program(6'd0);
  endtask

  task automatic test_random_ops();
    int         i;
    slot_addr_t c;
    opcode_e    code;
    for (i = 0; i < 16; i++) begin
      op_rng = xorshift32(op_rng);
      put_slot({4'h6, 4'(i)}, PT_FE, elem_t'(op_rng % MODULUS));
    end
    rdy_random <= 1'b1;
    pc = '0;
    for (i = 0; i < 15; i++) begin
      op_rng = xorshift32(op_rng);
      c    = {4'h7, 4'(i)};
      code = op_rng[8] ? OP_SUB : OP_ADD;
      put_inst(code, {4'h6, op_rng[3:0]}, {4'h6, op_rng[7:4]}, c);
      put_inst(OP_SEND_IRQ, c, c, 8'd0);
    end
    put_inst(OP_NOOP_WAIT, 8'd0, 8'd0, 8'd0);
    run_program(6'd0);
    rdy_random <= 1'b0;
  endtask

  // Back-to-back sends with ready held low, so both FIFOs fill and SEND_IRQ stalls
  task automatic test_backpressure();
    int i;
    pc = '0;
    for (i = 0; i < 8; i++) begin
      put_inst(OP_SEND_IRQ, {4'h7, 4'(i)}, {4'h7, 4'(i)}, 8'd0);
    end
    put_inst(OP_NOOP_WAIT, 8'd0, 8'd0, 8'd0);
    stall_until = cycles + 200;
    run_program(6'd0);
  endtask

  // Second program well away from address zero, with one unknown code
  task automatic test_restart();
    put_slot(8'd200, PT_FE, 16'd1234);
    put_slot(8'd201, PT_FE, 16'd65520);
    pc = 6'd48;
    put_inst(OP_SUB, 8'd200, 8'd201, 8'd202);
    put_inst(opcode_e'(4'hf), 8'd0, 8'd0, 8'd0);
    put_inst(OP_COPY, 8'd202, 8'd203, 8'd0);
    put_inst(OP_ADD, 8'd203, 8'd200, 8'd204);
    put_inst(OP_SEND_IRQ, 8'd202, 8'd202, 8'd0);
    put_inst(OP_SEND_IRQ, 8'd204, 8'd99, 8'd0);
    put_inst(OP_NOOP_WAIT, 8'd0, 8'd0, 8'd0);
    run_program(6'd48);
  endtask

  initial begin
    i_rst      = 1'b1;
    i_inst_wr  = '0;
    i_data_wr  = '0;
    i_start    = 1'b0;
    i_start_pt = '0;
    rdy_random = 1'b0;
    op_rng     = SEED;
    pc         = '0;
    repeat (8) @(posedge i_clk);
    i_rst <= 1'b0;
    check_idle_after_reset();
    test_fe_arith();
    test_fe2_and_copy();
    test_random_ops();
    test_backpressure();
    test_restart();
    repeat (20) @(posedge i_clk);
    if (coproc_top_inst.asserts_inst.fail_count == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("%0d assertion failures", coproc_top_inst.asserts_inst.fail_count);
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

//--- list.f
coproc_pkg.sv
coproc_mem.sv
coproc_sequencer.sv
coproc_mod_addsub.sv
coproc_fifo.sv
coproc_irq_sender.sv
coproc_top.sv
coproc_asserts.sv
coproc_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build the coprocessor testbench with Verilator, run it, look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -Wno-fatal --top-module coproc_tb -f list.f -o coproc_sim \
  && ./obj_dir/coproc_sim | tee /dev/stderr | grep -q "ALL TESTS PASSED" \
  && echo "Simulation run passed" \
  || { echo "Simulation run failed"; exit 1; }
